/* include/mem_tile_config.svh */
////////////////////////////////////////
// Widths, bank geometry and response
// latency of the memory tile
////////////////////////////////////////

`ifndef MEM_TILE_CONFIG_SVH
`define MEM_TILE_CONFIG_SVH

// Bus side
`define MT_DATA_W 32
`define MT_ADDR_W 12
`define MT_AID_W 4

// SRAM side
`define MT_SRAM_DATA_W 16
`define MT_BANKS_PER_WORD 2
`define MT_BANK_ROWS 4
`define MT_SRAM_WORDS 256

// Grant to rvalid for plain requests
`define MT_RSP_LATENCY 3

`endif

/* source/tile_bus_pkg.sv */
////////////////////////////////////////
// Bus level types: address, data, byte
// enable, request ID and atomic opcode
////////////////////////////////////////

`include "mem_tile_config.svh"

package tile_bus_pkg;

  typedef logic [`MT_ADDR_W-1:0] addr_t;
  typedef logic [`MT_DATA_W-1:0] data_t;
  typedef logic [`MT_DATA_W/8-1:0] be_t;
  typedef logic [`MT_AID_W-1:0] aid_t;

  // Atomic operations, all return the old word
  typedef enum logic [2:0] {
    ATOP_NONE = 3'd0,
    ATOP_SWAP = 3'd1,
    ATOP_ADD  = 3'd2,
    ATOP_AND  = 3'd3,
    ATOP_OR   = 3'd4,
    ATOP_XOR  = 3'd5
  } atop_e;

endpackage

/* source/tile_sram_pkg.sv */
////////////////////////////////////////
// SRAM level types: macro address, data,
// byte enable and row select
////////////////////////////////////////

`include "mem_tile_config.svh"

package tile_sram_pkg;

  // Word index inside one macro
  typedef logic [$clog2(`MT_SRAM_WORDS)-1:0] sram_addr_t;
  typedef logic [`MT_SRAM_DATA_W-1:0] sram_data_t;
  typedef logic [`MT_SRAM_DATA_W/8-1:0] sram_be_t;

  // Macro row inside one bank
  typedef logic [$clog2(`MT_BANK_ROWS)-1:0] row_sel_t;

endpackage

/* source/obi_bus_if.sv */
////////////////////////////////////////
// Internal request/response bus with
// manager and subordinate views
////////////////////////////////////////

interface obi_bus_if ();
  import tile_bus_pkg::*;

  // Request, a one cycle strobe that is always taken
  logic  req;
  logic  we;
  addr_t addr;
  data_t wdata;
  be_t   be;
  aid_t  aid;

  // Response, a one cycle strobe
  logic  rvalid;
  data_t rdata;
  aid_t  rid;

  modport mgr (
    output req, we, addr, wdata, be, aid,
    input  rvalid, rdata, rid
  );

  modport sbr (
    input  req, we, addr, wdata, be, aid,
    output rvalid, rdata, rid
  );

endinterface

/* source/sram_macro.sv */
////////////////////////////////////////
// Single port SRAM macro, byte enables,
// one cycle read latency
////////////////////////////////////////

module sram_macro (
  input  logic                      clk_i,
  input  logic                      req_i,
  input  logic                      we_i,
  input  tile_sram_pkg::sram_addr_t addr_i,
  input  tile_sram_pkg::sram_data_t wdata_i,
  input  tile_sram_pkg::sram_be_t   be_i,
  output tile_sram_pkg::sram_data_t rdata_o
);
  import tile_sram_pkg::*;

  localparam int unsigned NumWords = 2 ** $bits(sram_addr_t);
  localparam int unsigned NumBytes = $bits(sram_be_t);

  sram_data_t mem_q [NumWords];
  sram_data_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int unsigned b = 0; b < NumBytes; b++) begin
          if (be_i[b]) begin
            mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[addr_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

/* source/sram_banks.sv */
////////////////////////////////////////
// Banked SRAM array: address split, row
// decode and response generation
////////////////////////////////////////

`include "mem_tile_config.svh"

module sram_banks (
  input  logic   clk_i,
  input  logic   rst_n_i,
  obi_bus_if.sbr sbr_bus
);
  import tile_bus_pkg::*;
  import tile_sram_pkg::*;

  localparam int unsigned NumBanks   = `MT_BANKS_PER_WORD;
  localparam int unsigned NumRows    = `MT_BANK_ROWS;
  localparam int unsigned AddrOffset = $clog2(`MT_DATA_W / 8);
  localparam int unsigned RowOffset  = AddrOffset + $bits(sram_addr_t);
  localparam int unsigned BankDataW  = $bits(sram_data_t);
  localparam int unsigned BankBeW    = $bits(sram_be_t);

  sram_addr_t                             sram_addr;
  row_sel_t                               row_sel, row_sel_q;
  sram_data_t [NumBanks-1:0]              sram_wdata;
  sram_be_t   [NumBanks-1:0]              sram_be;
  sram_data_t [NumRows-1:0][NumBanks-1:0] sram_rdata;
  data_t                                  read_word;
  logic                                   rvalid_q;
  logic                                   we_q;
  aid_t                                   rid_q;

  assign sram_addr = sbr_bus.addr[AddrOffset +: $bits(sram_addr_t)];
  assign row_sel   = sbr_bus.addr[RowOffset +: $bits(row_sel_t)];

  for (genvar i = 0; i < NumBanks; i++) begin : gen_bank_split
    assign sram_wdata[i] = sbr_bus.wdata[i*BankDataW +: BankDataW];
    assign sram_be[i]    = sbr_bus.be[i*BankBeW +: BankBeW];
    // Registered row picks the macro that answered
    assign read_word[i*BankDataW +: BankDataW] = sram_rdata[row_sel_q][i];
  end

  for (genvar i = 0; i < NumBanks; i++) begin : gen_banks
    for (genvar j = 0; j < NumRows; j++) begin : gen_rows
      sram_macro i_mem (
        .clk_i,
        .req_i  (sbr_bus.req && (row_sel == row_sel_t'(j))),
        .we_i   (sbr_bus.we),
        .addr_i (sram_addr),
        .wdata_i(sram_wdata[i]),
        .be_i   (sram_be[i]),
        .rdata_o(sram_rdata[j][i])
      );
    end
  end

  ////////////////////////////////////////
  // Response
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= sbr_bus.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (sbr_bus.req) begin
      we_q  <= sbr_bus.we;
      rid_q <= sbr_bus.aid;
    end
    if (sbr_bus.req && !sbr_bus.we) begin
      row_sel_q <= row_sel;
    end
  end

  assign sbr_bus.rvalid = rvalid_q;
  assign sbr_bus.rid    = rid_q;
  // Writes answer with zero data
  assign sbr_bus.rdata  = we_q ? '0 : read_word;

endmodule

/* source/obi_cut.sv */
////////////////////////////////////////
// Register slice on the request and the
// response path of the internal bus
////////////////////////////////////////

module obi_cut (
  input  logic   clk_i,
  input  logic   rst_n_i,
  obi_bus_if.sbr sbr_bus,
  obi_bus_if.mgr mgr_bus
);
  import tile_bus_pkg::*;

  logic  req_q;
  logic  we_q;
  addr_t addr_q;
  data_t wdata_q;
  be_t   be_q;
  aid_t  aid_q;
  logic  rvalid_q;
  data_t rdata_q;
  aid_t  rid_q;

  // Strobes
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      req_q    <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      req_q    <= sbr_bus.req;
      rvalid_q <= mgr_bus.rvalid;
    end
  end

  // Payload, loaded only with its strobe
  always_ff @(posedge clk_i) begin
    if (sbr_bus.req) begin
      we_q    <= sbr_bus.we;
      addr_q  <= sbr_bus.addr;
      wdata_q <= sbr_bus.wdata;
      be_q    <= sbr_bus.be;
      aid_q   <= sbr_bus.aid;
    end
    if (mgr_bus.rvalid) begin
      rdata_q <= mgr_bus.rdata;
      rid_q   <= mgr_bus.rid;
    end
  end

  assign mgr_bus.req   = req_q;
  assign mgr_bus.we    = we_q;
  assign mgr_bus.addr  = addr_q;
  assign mgr_bus.wdata = wdata_q;
  assign mgr_bus.be    = be_q;
  assign mgr_bus.aid   = aid_q;

  assign sbr_bus.rvalid = rvalid_q;
  assign sbr_bus.rdata  = rdata_q;
  assign sbr_bus.rid    = rid_q;

endmodule

/* source/obi_atop_resolver.sv */
////////////////////////////////////////
// Request grant, outstanding response
// count and atomics as read-modify-write
////////////////////////////////////////

`include "mem_tile_config.svh"

module obi_atop_resolver (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  tile_bus_pkg::addr_t addr_i,
  input  tile_bus_pkg::data_t wdata_i,
  input  tile_bus_pkg::be_t   be_i,
  input  tile_bus_pkg::atop_e atop_i,
  input  tile_bus_pkg::aid_t  aid_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  output tile_bus_pkg::data_t rdata_o,
  output tile_bus_pkg::aid_t  rid_o,
  obi_bus_if.mgr              mgr_bus
);
  import tile_bus_pkg::*;

  localparam int unsigned CntW = $clog2(`MT_RSP_LATENCY + 1) + 1;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_AMO_RD,
    ST_AMO_WR
  } state_e;

  state_e          state_q, state_d;
  logic [CntW-1:0] cnt_q, cnt_d;
  logic            is_atop;
  logic            atop_wait;
  logic            amo_start;
  addr_t           amo_addr_q;
  data_t           amo_operand_q;
  aid_t            amo_aid_q;
  atop_e           amo_op_q;
  data_t           amo_result;

  function automatic data_t amo_calc(atop_e op, data_t old_word, data_t operand);
    data_t res;
    case (op)
      ATOP_SWAP: res = operand;
      ATOP_ADD:  res = old_word + operand;
      ATOP_AND:  res = old_word & operand;
      ATOP_OR:   res = old_word | operand;
      ATOP_XOR:  res = old_word ^ operand;
      default:   res = old_word;
    endcase
    return res;
  endfunction

  ////////////////////////////////////////
  // Grant
  ////////////////////////////////////////

  assign is_atop   = (atop_i != ATOP_NONE);
  // An atomic needs an empty pipeline
  assign atop_wait = req_i && is_atop && (cnt_q != '0);
  assign gnt_o     = (state_q == ST_IDLE) && !atop_wait;
  assign amo_start = gnt_o && req_i && is_atop;

  assign amo_result = amo_calc(amo_op_q, mgr_bus.rdata, amo_operand_q);

  always_comb begin
    state_d       = state_q;
    mgr_bus.req   = 1'b0;
    mgr_bus.we    = we_i;
    mgr_bus.addr  = addr_i;
    mgr_bus.wdata = wdata_i;
    mgr_bus.be    = be_i;
    mgr_bus.aid   = aid_i;
    rvalid_o      = mgr_bus.rvalid;
    rdata_o       = mgr_bus.rdata;
    rid_o         = mgr_bus.rid;
    case (state_q)
      ST_IDLE: begin
        mgr_bus.req = req_i && gnt_o;
        if (req_i && is_atop) begin
          // Read half of the atomic
          mgr_bus.we = 1'b0;
        end
        if (amo_start) begin
          state_d = ST_AMO_RD;
        end
      end
      ST_AMO_RD: begin
        mgr_bus.we   = 1'b0;
        mgr_bus.addr = amo_addr_q;
        mgr_bus.aid  = amo_aid_q;
        rid_o        = amo_aid_q;
        // Old word goes out while the new one is written
        if (mgr_bus.rvalid) begin
          mgr_bus.req   = 1'b1;
          mgr_bus.we    = 1'b1;
          mgr_bus.wdata = amo_result;
          mgr_bus.be    = '1;
          state_d       = ST_AMO_WR;
        end
      end
      ST_AMO_WR: begin
        mgr_bus.addr = amo_addr_q;
        mgr_bus.aid  = amo_aid_q;
        // Write response is swallowed
        rvalid_o     = 1'b0;
        if (mgr_bus.rvalid) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  ////////////////////////////////////////
  // Outstanding responses
  ////////////////////////////////////////

  always_comb begin
    cnt_d = cnt_q;
    if (mgr_bus.req && !mgr_bus.rvalid) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!mgr_bus.req && mgr_bus.rvalid) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // Atomic context
  always_ff @(posedge clk_i) begin
    if (amo_start) begin
      amo_addr_q    <= addr_i;
      amo_operand_q <= wdata_i;
      amo_aid_q     <= aid_i;
      amo_op_q      <= atop_i;
    end
  end

endmodule

/* source/mem_tile.sv */
////////////////////////////////////////
// Memory tile top: atomic resolver, cut
// stage and banked SRAM array
////////////////////////////////////////

module mem_tile (
  input  logic                clk_i,
  input  logic                rst_n_i,
  // Request
  input  logic                req_i,
  input  logic                we_i,
  input  tile_bus_pkg::addr_t addr_i,
  input  tile_bus_pkg::data_t wdata_i,
  input  tile_bus_pkg::be_t   be_i,
  input  tile_bus_pkg::atop_e atop_i,
  input  tile_bus_pkg::aid_t  aid_i,
  output logic                gnt_o,
  // Response
  output logic                rvalid_o,
  output tile_bus_pkg::data_t rdata_o,
  output tile_bus_pkg::aid_t  rid_o
);

  // Resolver to cut, and cut to the banks
  obi_bus_if bus_res ();
  obi_bus_if bus_mem ();

  obi_atop_resolver i_atop_resolver (
    .clk_i,
    .rst_n_i,
    .req_i,
    .we_i,
    .addr_i,
    .wdata_i,
    .be_i,
    .atop_i,
    .aid_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .rid_o,
    .mgr_bus (bus_res)
  );

  obi_cut i_obi_cut (
    .clk_i,
    .rst_n_i,
    .sbr_bus (bus_res),
    .mgr_bus (bus_mem)
  );

  sram_banks i_sram_banks (
    .clk_i,
    .rst_n_i,
    .sbr_bus (bus_mem)
  );

endmodule

/* testbench/mem_tile_checker.sv */
////////////////////////////////////////
// Protocol assertions on the memory tile
// top level, bound into mem_tile
////////////////////////////////////////

`include "mem_tile_config.svh"

module mem_tile_checker (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                req_i,
  input tile_bus_pkg::atop_e atop_i,
  input logic                gnt_i,
  input logic                rvalid_i
);
  timeunit 1ns;
  timeprecision 1ps;
  import tile_bus_pkg::*;

  int unsigned fail_cnt = 0;
  int unsigned pending_q;
  logic        granted;

  assign granted = req_i && gnt_i;

  // Responses still owed to the requester
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= 0;
    end else if (granted && !rvalid_i) begin
      pending_q <= pending_q + 1;
    end else if (!granted && rvalid_i) begin
      pending_q <= pending_q - 1;
    end
  end

  rvalid_low_in_reset: assert property (@(posedge clk_i)
    (!rst_n_i && !$past(rst_n_i)) |-> !rvalid_i)
    else begin
      fail_cnt++;
      $error("rvalid_o went high while reset was held");
    end

  plain_rsp_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (granted && atop_i == ATOP_NONE && pending_q == 0) |-> ##`MT_RSP_LATENCY rvalid_i)
    else begin
      fail_cnt++;
      $error("plain request on an idle tile did not answer after the fixed latency");
    end

  atop_blocks_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (granted && atop_i != ATOP_NONE) |=> !gnt_i)
    else begin
      fail_cnt++;
      $error("gnt_o stayed high in the cycle after an atomic was granted");
    end

endmodule

bind mem_tile mem_tile_checker i_mem_tile_checker (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .req_i   (req_i),
  .atop_i  (atop_i),
  .gnt_i   (gnt_o),
  .rvalid_i(rvalid_o)
);

/* testbench/tb_mem_tile.sv */
////////////////////////////////////////
// Memory tile testbench with golden file
// stimulus, response scoreboard, compare
// tasks and watchdog
////////////////////////////////////////

`include "mem_tile_config.svh"

module tb_mem_tile;
  timeunit 1ns;
  timeprecision 1ps;
  import tile_bus_pkg::*;

  typedef struct packed {
    logic [3:0] test;
    logic       we;
    addr_t      addr;
    data_t      wdata;
    be_t        be;
    atop_e      atop;
    aid_t       aid;
    data_t      exp;
  } stim_t;

  typedef struct packed {
    logic [3:0]  test;
    data_t       data;
    aid_t        aid;
    logic        atomic;
    logic [31:0] cycle;
  } resp_t;

  logic  clk_i;
  logic  rst_n_i;
  logic  req_i;
  logic  we_i;
  addr_t addr_i;
  data_t wdata_i;
  be_t   be_i;
  atop_e atop_i;
  aid_t  aid_i;
  logic  gnt_o;
  logic  rvalid_o;
  data_t rdata_o;
  aid_t  rid_o;

  stim_t       stim_q[$];
  resp_t       exp_q[$];
  stim_t       cur;
  logic [15:0] lfsr_state = 16'd15501;
  bit          stim_loaded = 1'b0;
  int unsigned cycle_cnt = 0;
  int unsigned checked_cnt = 0;

  mem_tile i_dut (
    .clk_i, .rst_n_i, .req_i, .we_i, .addr_i, .wdata_i, .be_i,
    .atop_i, .aid_i, .gnt_o, .rvalid_o, .rdata_o, .rid_o
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  function automatic string test_name(input logic [3:0] t);
    case (t)
      4'd1:    return "row_write_read";
      4'd2:    return "partial_write";
      4'd3:    return "back_to_back_read";
      4'd4:    return "atomic_ops";
      4'd5:    return "atomic_after_reads";
      default: return "unknown";
    endcase
  endfunction

  // Galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  task automatic pick_gap(output int gap);
    gap = 0;
    repeat (2) begin
      gap = (gap << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic stop_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("Fail %s: rdata expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic compare_id(input string name, input aid_t exp, input aid_t act);
    if (act !== exp) begin
      $display("Fail %s: rid expected %h actual %h", name, exp, act);
      stop_run();
    end
  endtask

  task automatic load_golden();
    int          fd;
    int          n;
    int          t;
    string       line;
    logic [31:0] we_v;
    logic [31:0] addr_v;
    logic [31:0] wdata_v;
    logic [31:0] be_v;
    logic [31:0] atop_v;
    logic [31:0] aid_v;
    logic [31:0] exp_v;
    stim_t       e;
    fd = $fopen("testbench/mem_tile_golden.txt", "r");
    if (fd == 0) begin
      $display("Could not open the golden stimulus file");
      stop_run();
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          n = $sscanf(line, "%d %h %h %h %h %h %h %h",
                      t, we_v, addr_v, wdata_v, be_v, atop_v, aid_v, exp_v);
          if (n != 8) begin
            $display("Malformed golden line: %s", line);
            stop_run();
          end else begin
            e.test  = t[3:0];
            e.we    = we_v[0];
            e.addr  = addr_t'(addr_v);
            e.wdata = wdata_v;
            e.be    = be_t'(be_v);
            e.atop  = atop_e'(atop_v[2:0]);
            e.aid   = aid_t'(aid_v);
            e.exp   = exp_v;
            stim_q.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Holds the request until the grant is seen
  task automatic send_request(input stim_t e, input bit grant_expected);
    cur     = e;
    req_i   = 1'b1;
    we_i    = e.we;
    addr_i  = e.addr;
    wdata_i = e.wdata;
    be_i    = e.be;
    atop_i  = e.atop;
    aid_i   = e.aid;
    @(posedge clk_i);
    if (grant_expected && !gnt_o) begin
      $display("Fail %s: gnt expected 1 actual %b", test_name(e.test), gnt_o);
      stop_run();
    end
    while (!gnt_o) @(posedge clk_i);
    @(negedge clk_i);
    req_i = 1'b0;
  endtask

  ////////////////////////////////////////
  // Scoreboard
  ////////////////////////////////////////

  initial begin : monitor
    resp_t sent;
    resp_t got;
    forever begin
      @(posedge clk_i);
      cycle_cnt++;
      if (i_dut.i_mem_tile_checker.fail_cnt != 0) begin
        $display("A protocol assertion on the DUT failed");
        stop_run();
      end
      if (rst_n_i && req_i && gnt_o) begin
        sent.test   = cur.test;
        sent.data   = cur.exp;
        sent.aid    = aid_i;
        sent.atomic = (atop_i != ATOP_NONE);
        sent.cycle  = cycle_cnt;
        exp_q.push_back(sent);
      end
      if (rst_n_i && rvalid_o) begin
        if (exp_q.size() == 0) begin
          $display("Response with ID %h arrived with no request outstanding", rid_o);
          stop_run();
        end else begin
          got = exp_q.pop_front();
          compare_id(test_name(got.test), got.aid, rid_o);
          compare_data(test_name(got.test), got.data, rdata_o);
          if (!got.atomic && (cycle_cnt - got.cycle != `MT_RSP_LATENCY)) begin
            $display("Fail %s: latency expected %0d actual %0d", test_name(got.test),
                     `MT_RSP_LATENCY, cycle_cnt - got.cycle);
            stop_run();
          end
          checked_cnt++;
        end
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (stim_loaded);
    limit = stim_q.size() * 16 + 64;
    repeat (limit) @(posedge clk_i);
    $display("Timeout: the run did not finish within %0d cycles", limit);
    stop_run();
  end

  initial begin : stimulus
    int gap;
    bit prev_atomic;
    rst_n_i = 1'b0;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    atop_i  = ATOP_NONE;
    aid_i   = '0;
    prev_atomic = 1'b0;
    load_golden();
    stim_loaded = 1'b1;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    foreach (stim_q[i]) begin
      // Only an atomic takes the resolver out of its granting state
      send_request(stim_q[i], !prev_atomic && (stim_q[i].atop == ATOP_NONE));
      prev_atomic = (stim_q[i].atop != ATOP_NONE);
      // Reads in tests 3 and 5 go back to back
      if (stim_q[i].test == 4'd3 || stim_q[i].test == 4'd5) begin
        gap = 0;
      end else begin
        pick_gap(gap);
      end
      repeat (gap) @(negedge clk_i);
    end
    while (checked_cnt != stim_q.size()) @(posedge clk_i);
    repeat (4) @(posedge clk_i);
    if (exp_q.size() == 0 && i_dut.i_mem_tile_checker.fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("Responses or protocol checks left unresolved at the end of the run");
      stop_run();
    end
  end

endmodule

/* build.f */
+incdir+include
source/tile_bus_pkg.sv
source/tile_sram_pkg.sv
source/obi_bus_if.sv
source/sram_macro.sv
source/sram_banks.sv
source/obi_cut.sv
source/obi_atop_resolver.sv
source/mem_tile.sv
testbench/mem_tile_checker.sv
testbench/tb_mem_tile.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the memory tile testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_mem_tile -f build.f -o sim_mem_tile
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/sim_mem_tile +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
  exit 0
else
  exit 1
fi

/* testbench/mem_tile_golden.txt */
# test we addr wdata be atop aid expected_rdata, all hex except test
# atop: 0 none, 1 swap, 2 add, 3 and, 4 or, 5 xor
1 1 010 11223344 f 0 0 00000000
1 1 410 55667788 f 0 1 00000000
1 1 810 99aabbcc f 0 2 00000000
1 1 c10 ddeeff00 f 0 3 00000000
1 0 010 00000000 f 0 4 11223344
1 0 410 00000000 f 0 5 55667788
1 0 810 00000000 f 0 6 99aabbcc
1 0 c10 00000000 f 0 7 ddeeff00
2 1 100 12345678 f 0 8 00000000
2 1 100 aabbccdd 5 0 9 00000000
2 1 100 eeff0011 a 0 a 00000000
2 0 100 00000000 f 0 b eebb00dd
3 0 c10 00000000 f 0 c ddeeff00
3 0 810 00000000 f 0 d 99aabbcc
3 0 410 00000000 f 0 e 55667788
3 0 100 00000000 f 0 f eebb00dd
4 1 200 00000010 f 0 0 00000000
4 0 200 12345678 0 1 1 00000010
4 0 200 ffffffff 0 2 2 12345678
4 0 200 0f0f0f0f 0 3 3 12345677
4 0 200 f0000000 0 4 4 02040607
4 1 200 ffff0000 0 5 5 f2040607
4 0 200 00000000 f 0 6 0dfb0607
5 0 010 00000000 f 0 7 11223344
5 0 410 00000000 f 0 8 55667788
5 0 810 00000000 f 0 9 99aabbcc
5 0 010 ffffffff 0 5 a 11223344
5 0 010 00000000 f 0 b eeddccbb
